/* verilog.f */
design/apb_periph_pkg.sv
design/apb_splitter.sv
design/gpio.sv
design/pwm_tiny.sv
design/riscboy_periph.sv
test/periph_checker.sv
test/tb_riscboy_periph.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the peripheral testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_riscboy_periph -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }

/* test/tb_riscboy_periph.sv */
`timescale 1ns/10ps

module tb_riscboy_periph
	import apb_periph_pkg::*;
();

localparam int          N_PADS     = 11;
localparam int          CLK_PERIOD = 8;
localparam logic [31:0] SEED       = 32'ha489;
localparam int          N_GPIO     = 12;
localparam int          N_PADIN    = 8;
localparam int          N_CTRL     = 6;
localparam int          N_PWM      = 3;
localparam int          N_UNMAPPED = 8;
localparam int          MAX_DIV    = 3;
localparam int          IDLE_CYC   = 64;

// Padin rounds count their idle wait as one extra transaction
localparam int N_TXN    = N_GPIO * 4 + N_PADIN * 2 + N_CTRL * 2 + N_PWM * 4 + 1
	+ N_UNMAPPED * 2 + 5;
localparam int PWM_CYC  = N_PWM * (256 * (MAX_DIV + 1) + 1) + IDLE_CYC;
localparam int TIMEOUT  = N_TXN * 3 + PWM_CYC + 4 + 200;

logic               clk_sys;
logic               rst_n;
logic [W_PADDR-1:0] paddr;
logic               psel;
logic               penable;
logic               pwrite;
logic [W_DATA-1:0]  pwdata;
logic [W_DATA-1:0]  prdata;
logic               pready;
logic               pslverr;
logic [N_PADS-1:0]  padin;
logic [N_PADS-1:0]  padout;
logic [N_PADS-1:0]  padoe;
logic               pwm_out;
logic               pwm_window;
int                 check_count;
int                 error_count;

riscboy_periph #(.N_PADS(N_PADS)) uut (
	.clk_sys (clk_sys), .rst_n (rst_n),
	.paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite), .pwdata (pwdata),
	.prdata (prdata), .pready (pready), .pslverr (pslverr),
	.padin (padin), .padout (padout), .padoe (padoe), .pwm_out (pwm_out)
);

periph_checker #(.N_PADS(N_PADS)) inst_checker (
	.clk_sys (clk_sys), .rst_n (rst_n),
	.paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite), .pwdata (pwdata),
	.prdata (prdata), .pready (pready), .pslverr (pslverr),
	.padin (padin), .padout (padout), .padoe (padoe), .pwm_out (pwm_out),
	.pwm_window (pwm_window), .check_count (check_count), .error_count (error_count)
);

initial begin
	clk_sys = 1'b0;
	forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
end

// Setup then access phase, called and returning on a falling edge
task automatic apb_transfer(input logic write, input logic [3:0] slot,
	input logic [W_OFFS-1:0] offs, input logic [W_DATA-1:0] data);
	paddr   = {slot, offs};
	pwrite  = write;
	pwdata  = data;
	psel    = 1'b1;
	penable = 1'b0;
	@(negedge clk_sys);
	penable = 1'b1;
	@(negedge clk_sys);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic measure_window(input int cycles);
	pwm_window = 1'b1;
	repeat (cycles) @(negedge clk_sys);
	pwm_window = 1'b0;
	@(negedge clk_sys);
endtask

// ==============================
// Stimulus
// ==============================

initial begin
	logic [7:0]        div;
	logic [W_DATA-1:0] word;
	logic [3:0]        slot;
	paddr      = '0;
	psel       = 1'b0;
	penable    = 1'b0;
	pwrite     = 1'b0;
	pwdata     = '0;
	padin      = '0;
	pwm_window = 1'b0;
	rst_n      = 1'b0;
	void'($urandom(SEED));
	repeat (4) @(posedge clk_sys);
	@(negedge clk_sys);
	rst_n = 1'b1;

	for (int i = 0; i < N_GPIO; i++) begin
		apb_transfer(1'b1, 4'(SLOT_GPIO), GPIO_OUT, $urandom());
		apb_transfer(1'b1, 4'(SLOT_GPIO), GPIO_OE, $urandom());
		apb_transfer(1'b0, 4'(SLOT_GPIO), GPIO_OUT, $urandom());
		apb_transfer(1'b0, 4'(SLOT_GPIO), GPIO_OE, $urandom());
	end
	for (int i = 0; i < N_PADIN; i++) begin
		padin = N_PADS'($urandom());
		repeat (3) @(negedge clk_sys);  // Settle through the synchroniser
		apb_transfer(1'b0, 4'(SLOT_GPIO), GPIO_IN, $urandom());
	end
	for (int i = 0; i < N_CTRL; i++) begin
		apb_transfer(1'b1, 4'(SLOT_PWM), PWM_CTRL, $urandom());
		apb_transfer(1'b0, 4'(SLOT_PWM), PWM_CTRL, $urandom());
	end

	// Duty cycle windows with the PWM enabled
	for (int i = 0; i < N_PWM; i++) begin
		div        = 8'($urandom_range(0, MAX_DIV));
		word       = $urandom();
		word[0]    = 1'b1;
		word[1]    = i[0];  // Both output polarities
		word[15:8] = div;
		apb_transfer(1'b1, 4'(SLOT_PWM), PWM_DUTY, $urandom());
		apb_transfer(1'b1, 4'(SLOT_PWM), PWM_CTRL, word);
		apb_transfer(1'b0, 4'(SLOT_PWM), PWM_CTRL, $urandom());
		apb_transfer(1'b0, 4'(SLOT_PWM), PWM_DUTY, $urandom());
		measure_window(256 * (int'(div) + 1));
	end
	word    = $urandom();
	word[0] = 1'b0;
	apb_transfer(1'b1, 4'(SLOT_PWM), PWM_CTRL, word);
	repeat (IDLE_CYC) @(negedge clk_sys);  // Output held at inv

	for (int i = 0; i < N_UNMAPPED; i++) begin
		slot = 4'($urandom_range(2, 15));
		word = $urandom();
		apb_transfer(1'b1, slot, W_OFFS'($urandom_range(0, 3) * 4), word);
		apb_transfer(1'b0, slot, W_OFFS'($urandom_range(0, 3) * 4), word);
	end
	apb_transfer(1'b0, 4'(SLOT_GPIO), GPIO_OUT, '0);
	apb_transfer(1'b0, 4'(SLOT_GPIO), GPIO_OE, '0);
	apb_transfer(1'b0, 4'(SLOT_GPIO), GPIO_IN, '0);
	apb_transfer(1'b0, 4'(SLOT_PWM), PWM_CTRL, '0);
	apb_transfer(1'b0, 4'(SLOT_PWM), PWM_DUTY, '0);

	repeat (2) @(negedge clk_sys);
	$display("Checks run: %0d, errors: %0d", check_count, error_count);
	if (error_count == 0)
		$display("All tests passed!");
	else
		$display("Test failures found");
	$finish;
end

// Watchdog
initial begin
	repeat (TIMEOUT) @(posedge clk_sys);
	$display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT);
	$display("Test failures found");
	$finish;
end

endmodule

/* test/periph_checker.sv */
`timescale 1ns/10ps

// Scoreboard for the peripheral subsystem. Mirrors register state from the
// observed APB writes and checks readback, bus response, pads and PWM output.

module periph_checker
	import apb_periph_pkg::*;
#(
	parameter N_PADS = 11
) (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic [W_PADDR-1:0] paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [W_DATA-1:0]  pwdata,
	input  logic [W_DATA-1:0]  prdata,
	input  logic               pready,
	input  logic               pslverr,
	input  logic [N_PADS-1:0]  padin,
	input  logic [N_PADS-1:0]  padout,
	input  logic [N_PADS-1:0]  padoe,
	input  logic               pwm_out,
	input  logic               pwm_window,  // High for exactly one PWM period
	output int                 check_count,
	output int                 error_count
);

localparam logic [W_DATA-1:0] CTRL_MASK = 32'h0000_ff03; // en, inv and div only

logic [N_PADS-1:0] m_out;
logic [N_PADS-1:0] m_oe;
logic [N_PADS-1:0] pad_d1;
logic [N_PADS-1:0] pad_d2;   // Value GPIO_IN should return now
logic [W_DATA-1:0] m_ctrl;
logic [7:0]        m_duty;
logic              access;
int                win_cycles;
int                win_high;
int                full_period;
int                exp_high;
int                checks = 0;
int                errors = 0;

assign check_count = checks;
assign error_count = errors;

task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
	end
endtask

// ==============================
// Register model
// ==============================

function automatic logic [W_DATA-1:0] expected_read(input logic [W_PADDR-1:0] addr);
	logic [W_DATA-1:0] val;
	val = '0;
	if (addr[15:12] == 4'(SLOT_GPIO)) begin
		case (addr[W_OFFS-1:0])
			GPIO_OUT: val = 32'(m_out);
			GPIO_OE:  val = 32'(m_oe);
			GPIO_IN:  val = 32'(pad_d2);
			default:  val = '0;
		endcase
	end else if (addr[15:12] == 4'(SLOT_PWM)) begin
		case (addr[W_OFFS-1:0])
			PWM_CTRL: val = m_ctrl;
			PWM_DUTY: val = 32'(m_duty);
			default:  val = '0;
		endcase
	end
	return val;
endfunction

task automatic apply_write(input logic [W_PADDR-1:0] addr, input logic [W_DATA-1:0] data);
	if (addr[15:12] == 4'(SLOT_GPIO)) begin
		if (addr[W_OFFS-1:0] == GPIO_OUT)
			m_out = data[N_PADS-1:0];
		else if (addr[W_OFFS-1:0] == GPIO_OE)
			m_oe = data[N_PADS-1:0];
	end else if (addr[15:12] == 4'(SLOT_PWM)) begin
		if (addr[W_OFFS-1:0] == PWM_CTRL)
			m_ctrl = data & CTRL_MASK;
		else if (addr[W_OFFS-1:0] == PWM_DUTY)
			m_duty = data[7:0];
	end
endtask

// High time over one period is duty*(div+1), complemented by inv
task automatic check_window();
	full_period = 256 * (int'(m_ctrl[15:8]) + 1);
	if (win_cycles != full_period) begin
		errors++;
		$display("PWM window lasted %0d cycles but one period is %0d cycles",
			win_cycles, full_period);
	end else begin
		exp_high = m_ctrl[0] ? int'(m_duty) * (int'(m_ctrl[15:8]) + 1) : 0;
		if (m_ctrl[1])
			exp_high = full_period - exp_high;
		compare("pwm_out high cycles", 32'(win_high), 32'(exp_high));
	end
endtask

// ==============================
// Monitor
// ==============================

// Sampled at the rising edge, so all DUT values are the ones before the edge
always @(posedge clk_sys) begin
	if (!rst_n) begin
		m_out      = '0;
		m_oe       = '0;
		pad_d1     = '0;
		pad_d2     = '0;
		m_ctrl     = '0;
		m_duty     = '0;
		win_cycles = 0;
		win_high   = 0;
	end else begin
		access = psel && penable;
		compare("pready", 32'(pready), 32'd1);
		compare("pslverr", 32'(pslverr), 32'(access && (paddr[15:12] > 4'd1)));
		if (access && !pwrite)
			compare($sformatf("prdata at 0x%04h", paddr), prdata, expected_read(paddr));
		compare("padout", 32'(padout), 32'(m_out));
		compare("padoe", 32'(padoe), 32'(m_oe));
		if (!m_ctrl[0])
			compare("pwm_out while disabled", 32'(pwm_out), 32'(m_ctrl[1]));

		if (pwm_window) begin
			win_cycles++;
			if (pwm_out === 1'b1)
				win_high++;
		end else if (win_cycles != 0) begin
			check_window();
			win_cycles = 0;
			win_high   = 0;
		end

		if (access && pwrite)
			apply_write(paddr, pwdata); // Visible from the next edge on
		pad_d2 = pad_d1;  // Two flop input path
		pad_d1 = padin;
	end
end

endmodule

/* design/riscboy_periph.sv */
`timescale 1ns/10ps

// Standalone peripheral subsystem on one APB slave port. The splitter
// steers each transfer to GPIO (slot 0) or the backlight PWM (slot 1).

module riscboy_periph
	import apb_periph_pkg::*;
#(
	parameter N_PADS = 11
) (
	input  logic               clk_sys,
	input  logic               rst_n,

	// APB slave port
	input  logic [W_PADDR-1:0] paddr,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [W_DATA-1:0]  pwdata,
	output logic [W_DATA-1:0]  prdata,
	output logic               pready,
	output logic               pslverr,

	// GPIO pads
	input  logic [N_PADS-1:0]  padin,
	output logic [N_PADS-1:0]  padout,
	output logic [N_PADS-1:0]  padoe,

	output logic               pwm_out  // LCD backlight
);

// ==============================
// Interconnect
// ==============================

logic              gpio_psel;
logic [W_DATA-1:0] gpio_prdata;
logic              pwm_psel;
logic [W_DATA-1:0] pwm_prdata;

apb_splitter inst_apb_splitter (
	.paddr       (paddr),
	.psel        (psel),
	.penable     (penable),
	.gpio_prdata (gpio_prdata),
	.pwm_prdata  (pwm_prdata),
	.gpio_psel   (gpio_psel),
	.pwm_psel    (pwm_psel),
	.prdata      (prdata),
	.pready      (pready),
	.pslverr     (pslverr)
);

// ==============================
// Slaves
// ==============================

// Address, enable, direction and write data fan out to both slaves
gpio #(
	.N_PADS (N_PADS)
) inst_gpio (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.psel    (gpio_psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (gpio_prdata),
	.padin   (padin),
	.padout  (padout),
	.padoe   (padoe)
);

pwm_tiny inst_pwm_tiny (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.psel    (pwm_psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (pwm_prdata),
	.pwm_out (pwm_out)
);

endmodule

/* design/pwm_tiny.sv */
`timescale 1ns/10ps

// Small PWM for the LCD backlight. An 8-bit prescaler counts 0..div and
// each wrap advances an 8-bit period counter. Output is high while the
// counter is below duty.

module pwm_tiny
	import apb_periph_pkg::*;
(
	input  logic               clk_sys,
	input  logic               rst_n,

	// APB slave
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [W_PADDR-1:0] paddr,
	input  logic [W_DATA-1:0]  pwdata,
	output logic [W_DATA-1:0]  prdata,

	output logic               pwm_out
);

// ==============================
// Bus decode
// ==============================

logic [W_OFFS-1:0] offs;
logic              wen;

assign offs = paddr[W_OFFS-1:0];
assign wen  = psel && penable && pwrite;

// ==============================
// Control and duty registers
// ==============================

pwm_csr_u   csr;
pwm_csr_u   wr_word;    // Incoming bus word viewed as fields
pwm_csr_u   csr_wdata;
logic [7:0] duty;

// Only the defined fields are kept, reserved bits stay zero
always_comb begin
	wr_word.raw       = pwdata;
	csr_wdata.raw     = {W_DATA{1'b0}};
	csr_wdata.f.en    = wr_word.f.en;
	csr_wdata.f.inv   = wr_word.f.inv;
	csr_wdata.f.div   = wr_word.f.div;
end

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		csr  <= '0;
		duty <= 8'h00;
	end else if (wen) begin
		if (offs == PWM_CTRL)
			csr <= csr_wdata;
		if (offs == PWM_DUTY)
			duty <= pwdata[7:0];
	end
end

always_comb begin
	case (offs)
		PWM_CTRL: prdata = csr.raw;
		PWM_DUTY: prdata = {{(W_DATA - 8){1'b0}}, duty};
		default:  prdata = {W_DATA{1'b0}};
	endcase
end

// ==============================
// Prescaler and period counter
// ==============================

logic [7:0] presc;
logic [7:0] ctr;

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		presc <= 8'h00;
		ctr   <= 8'h00;
	end else if (!csr.f.en) begin
		// Parked at the start of a period while disabled
		presc <= 8'h00;
		ctr   <= 8'h00;
	end else if (presc >= csr.f.div) begin
		// >= so a smaller div written mid-count still wraps
		presc <= 8'h00;
		ctr   <= ctr + 8'h01; // Wraps after 255
	end else begin
		presc <= presc + 8'h01;
	end
end

// Idle level is inv when disabled
assign pwm_out = (csr.f.en && (ctr < duty)) ^ csr.f.inv;

// Counter may only run once en has been seen set
assert_ctr_idle: assert property (
	@(posedge clk_sys) disable iff (!rst_n)
	!csr.f.en |=> ctr == 8'h00
) else $error("pwm_tiny: counter moved while disabled");

endmodule

/* design/gpio.sv */
`timescale 1ns/10ps

// Simple GPIO block. Output and output-enable registers drive the pads
// directly, inputs are brought into clk_sys through a 2-flop synchroniser.

module gpio
	import apb_periph_pkg::*;
#(
	parameter N_PADS = 11
) (
	input  logic               clk_sys,
	input  logic               rst_n,

	// APB slave
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [W_PADDR-1:0] paddr,
	input  logic [W_DATA-1:0]  pwdata,
	output logic [W_DATA-1:0]  prdata,

	// Pads
	input  logic [N_PADS-1:0]  padin,
	output logic [N_PADS-1:0]  padout,
	output logic [N_PADS-1:0]  padoe
);

// ==============================
// Bus decode
// ==============================

logic [W_OFFS-1:0] offs;
logic              wen;

assign offs = paddr[W_OFFS-1:0]; // Slot bits already decoded upstream
assign wen  = psel && penable && pwrite;

// ==============================
// Output registers
// ==============================

logic [N_PADS-1:0] out_q;
logic [N_PADS-1:0] oe_q;

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		out_q <= {N_PADS{1'b0}};
		oe_q  <= {N_PADS{1'b0}};
	end else if (wen) begin
		if (offs == GPIO_OUT)
			out_q <= pwdata[N_PADS-1:0];
		if (offs == GPIO_OE)
			oe_q <= pwdata[N_PADS-1:0];
		// GPIO_IN and unmapped offsets are ignored
	end
end

assign padout = out_q;
assign padoe  = oe_q;

// ==============================
// Input synchroniser
// ==============================

logic [N_PADS-1:0] in_meta;
logic [N_PADS-1:0] in_sync;

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		in_meta <= {N_PADS{1'b0}};
		in_sync <= {N_PADS{1'b0}};
	end else begin
		in_meta <= padin;   // May go metastable
		in_sync <= in_meta;
	end
end

// ==============================
// Readback
// ==============================

localparam W_PAD_ZEXT = W_DATA - N_PADS;

always_comb begin
	case (offs)
		GPIO_OUT: prdata = {{W_PAD_ZEXT{1'b0}}, out_q};
		GPIO_OE:  prdata = {{W_PAD_ZEXT{1'b0}}, oe_q};
		GPIO_IN:  prdata = {{W_PAD_ZEXT{1'b0}}, in_sync};
		default:  prdata = {W_DATA{1'b0}};
	endcase
end

// Pad drivers must never float to X once out of reset
assert_pads_known: assert property (
	@(posedge clk_sys) disable iff (!rst_n)
	!$isunknown({padout, padoe})
) else $error("gpio: padout/padoe unknown after reset");

endmodule

/* design/apb_splitter.sv */
`timescale 1ns/10ps

// Slot decoder for the peripheral APB segment. One slave per 4 kB slot,
// selected by the top nibble of paddr.

module apb_splitter
	import apb_periph_pkg::*;
(
	// Upstream request
	input  logic [W_PADDR-1:0] paddr,
	input  logic               psel,
	input  logic               penable,

	// Slave read data
	input  logic [W_DATA-1:0]  gpio_prdata,
	input  logic [W_DATA-1:0]  pwm_prdata,

	// Per-slave selects
	output logic               gpio_psel,
	output logic               pwm_psel,

	// Upstream response
	output logic [W_DATA-1:0]  prdata,
	output logic               pready,
	output logic               pslverr
);

// ==============================
// Slot decode
// ==============================

logic [W_SLOT-1:0]  slot;
logic [N_SLOTS-1:0] slot_hit;
logic               slot_mapped;

assign slot = paddr[W_PADDR-1 -: W_SLOT];

genvar i;
generate
for (i = 0; i < N_SLOTS; i = i + 1) begin: gen_slot_hit
	assign slot_hit[i] = slot == W_SLOT'(i);
end
endgenerate

assign slot_mapped = |slot_hit;

assign gpio_psel = psel && slot_hit[SLOT_GPIO];
assign pwm_psel  = psel && slot_hit[SLOT_PWM];

// ==============================
// Response path
// ==============================

// Read data follows the decoded slot, holes read as zero
always_comb begin
	prdata = {W_DATA{1'b0}};
	if (slot_hit[SLOT_GPIO])
		prdata = gpio_prdata;
	else if (slot_hit[SLOT_PWM])
		prdata = pwm_prdata;
end

assign pready  = 1'b1;                               // All slaves are zero-wait
assign pslverr = psel && penable && !slot_mapped;    // Error only in access phase

// ==============================
// Protocol checks
// ==============================

// A transfer enters its access phase with at most one slave selected
assert_one_slave_sel: assert property (
	@(posedge penable) $onehot0({gpio_psel, pwm_psel})
) else $error("apb_splitter: more than one slave selected");

// Master must hold psel through the access phase
assert_penable_needs_psel: assert property (
	@(posedge penable) psel
) else $error("apb_splitter: penable raised without psel");

endmodule

/* design/apb_periph_pkg.sv */
package apb_periph_pkg;

// ==============================
// Bus widths
// ==============================

localparam int W_PADDR = 16;
localparam int W_DATA  = 32;

// ==============================
// Address map
// ==============================

// Upper address nibble selects the slave, the rest is the register offset
localparam int W_SLOT  = 4;
localparam int W_OFFS  = W_PADDR - W_SLOT;
localparam int N_SLOTS = 2;

localparam int unsigned SLOT_GPIO = 0;
localparam int unsigned SLOT_PWM  = 1;

// GPIO registers
localparam logic [W_OFFS-1:0] GPIO_OUT = 12'h000;
localparam logic [W_OFFS-1:0] GPIO_OE  = 12'h004;
localparam logic [W_OFFS-1:0] GPIO_IN  = 12'h008; // Read only

// PWM registers
localparam logic [W_OFFS-1:0] PWM_CTRL = 12'h000;
localparam logic [W_OFFS-1:0] PWM_DUTY = 12'h004;

// ==============================
// PWM control word
// ==============================

// Same 32 bits seen as a bus word or as the control fields
typedef union packed {
	logic [W_DATA-1:0] raw;
	struct packed {
		logic [15:0] rsvd_hi;
		logic [7:0]  div;     // Prescaler terminal count
		logic [5:0]  rsvd_lo;
		logic        inv;     // Output polarity
		logic        en;
	} f;
} pwm_csr_u;

endpackage
